// File: design/sifhCfgPkg.sv
//********************
// Histogram engine configuration
// Timestamp, bin and counter widths
// Default frame geometry for the top level
//********************

`default_nettype none

package sifhCfgPkg;

    // Timestamp width in LSB codes
    localparam int NP = 8;

    // Bin index width, same for coarse and fine pass
    localparam int NB = 4;

    // Bins in one pixel histogram
    localparam int BINS = 2 ** NB;

    // Saturating bin counter width
    localparam int CNT_W = 8;

    // Pixel index field, room for up to 256 pixels
    localparam int PIX_W = 8;

    //********************
    // Default counts per acquisition and pass
    localparam int PIXELS_DEF = 4;
    localparam int SAMPLES_DEF = 4;
    localparam int ACQS_DEF = 2;

endpackage

`default_nettype wire

// File: design/sifhTypesPkg.sv
//********************
// Histogram engine types
// Sample word with raw and coarse views
// Pass enumeration, bin update and peak entry
//********************

`default_nettype none

package sifhTypesPkg;

    //********************
    // Input sample

    // Coarse bin in the top bits, LSB remainder below
    typedef struct packed {
        logic [sifhCfgPkg::NB-1:0]                coarse;
        logic [sifhCfgPkg::NP-sifhCfgPkg::NB-1:0] lsb;
    } sampleSplit_t;

    // One timestamp word, read split in the coarse pass and raw in the fine pass
    typedef union packed {
        logic [sifhCfgPkg::NP-1:0] raw;
        sampleSplit_t              split;
    } sampleWord_u;

    //********************
    // Pipeline words

    // Histogram pass
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } pass_e;

    // Increment request for one bin of one pixel
    typedef struct packed {
        logic                         valid;
        logic [sifhCfgPkg::PIX_W-1:0] pix;
        logic [sifhCfgPkg::NB-1:0]    bin;
    } binUpd_t;

    // Bin with its count
    typedef struct packed {
        logic [sifhCfgPkg::NB-1:0]    bin;
        logic [sifhCfgPkg::CNT_W-1:0] count;
    } peak_t;

endpackage

`default_nettype wire

// File: design/sifhControl.sv
//********************
// Frame sequencer of the peak finder
// Sample, pixel and acquisition counters
// Pass FSM with drain, window latch, result and clear phases
//********************

`timescale 1ns/1ps
`default_nettype none

module sifhControl #(
    parameter int PIXELS  = sifhCfgPkg::PIXELS_DEF,
    parameter int SAMPLES = sifhCfgPkg::SAMPLES_DEF,
    parameter int ACQS    = sifhCfgPkg::ACQS_DEF
) (
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         inValid,
    output logic                         inReady,
    input  logic                         outReady,
    output logic                         outValid,
    output logic                         accept,
    output sifhTypesPkg::pass_e          pass,
    output logic [sifhCfgPkg::PIX_W-1:0] pixIdx,
    output logic                         latchWin,
    output logic                         clear
);

    localparam int SMP_W = $clog2(SAMPLES + 1);
    localparam int ACQ_W = $clog2(ACQS + 1);

    // FSM encoding
    localparam logic [2:0] ST_ACCEPT = 3'd0;
    localparam logic [2:0] ST_DRAIN0 = 3'd1;
    localparam logic [2:0] ST_DRAIN1 = 3'd2;
    localparam logic [2:0] ST_WRAP   = 3'd3;
    localparam logic [2:0] ST_OUTPUT = 3'd4;
    localparam logic [2:0] ST_CLEAR  = 3'd5;

    logic [2:0]       state;
    logic [SMP_W-1:0] smpCnt;
    logic [ACQ_W-1:0] acqCnt;
    logic             smpLast;
    logic             pixLast;
    logic             acqLast;
    logic             lastAccept;

    //********************
    // Handshake and phase outputs

    // Samples taken only in the accept phase
    assign inReady = (state == ST_ACCEPT);
    assign accept = inValid && inReady;
    assign outValid = (state == ST_OUTPUT);

    // Window latched once the coarse peaks have settled
    assign latchWin = (state == ST_WRAP) && (pass == sifhTypesPkg::COARSE);
    // Histograms and peaks wiped between passes and after each result
    assign clear = latchWin || (state == ST_CLEAR);

    // Position in the frame
    assign smpLast = (smpCnt == SMP_W'(SAMPLES - 1));
    assign pixLast = (pixIdx == sifhCfgPkg::PIX_W'(PIXELS - 1));
    assign acqLast = (acqCnt == ACQ_W'(ACQS - 1));
    assign lastAccept = accept && smpLast && pixLast && acqLast;

    //********************
    // Frame counters

    // All three wrap to zero on the last sample of a pass
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            smpCnt <= '0;
            pixIdx <= '0;
            acqCnt <= '0;
        end else if (accept) begin
            if (smpLast) begin
                smpCnt <= '0;
                if (pixLast) begin
                    pixIdx <= '0;
                    acqCnt <= acqLast ? '0 : acqCnt + 1'b1;
                end else begin
                    pixIdx <= pixIdx + 1'b1;
                end
            end else begin
                smpCnt <= smpCnt + 1'b1;
            end
        end
    end

    //********************
    // Pass FSM

    // Two drain cycles cover the filter and bank stages
    // Wrap cycle lets the peak table and result register settle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= ST_ACCEPT;
            pass <= sifhTypesPkg::COARSE;
        end else begin
            case (state)
                ST_ACCEPT: begin
                    if (lastAccept) begin
                        state <= ST_DRAIN0;
                    end
                end
                ST_DRAIN0: state <= ST_DRAIN1;
                ST_DRAIN1: state <= ST_WRAP;
                ST_WRAP: begin
                    // Coarse pass goes straight on to the fine pass
                    if (pass == sifhTypesPkg::COARSE) begin
                        state <= ST_ACCEPT;
                        pass <= sifhTypesPkg::FINE;
                    end else begin
                        state <= ST_OUTPUT;
                    end
                end
                ST_OUTPUT: begin
                    // Result held until taken
                    if (outReady) begin
                        state <= ST_CLEAR;
                        pass <= sifhTypesPkg::COARSE;
                    end
                end
                ST_CLEAR: state <= ST_ACCEPT;
                default: state <= ST_ACCEPT;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/sampleFilter.sv
//********************
// Sample filter
// Coarse bin select or fine window test
// Registered bin update
//********************

`timescale 1ns/1ps
`default_nettype none

module sampleFilter #(
    parameter int PIXELS = sifhCfgPkg::PIXELS_DEF
) (
    input  logic                                  clk,
    input  logic                                  combin_res,
    input  logic                                  accept,
    input  sifhTypesPkg::pass_e                   pass,
    input  logic [sifhCfgPkg::PIX_W-1:0]          pixIdx,
    input  sifhTypesPkg::sampleWord_u             inData,
    input  logic [PIXELS*sifhCfgPkg::NP-1:0]      winLow,
    output sifhTypesPkg::binUpd_t                 upd
);

    logic [sifhCfgPkg::NP-1:0]    low;
    logic [sifhCfgPkg::NP-1:0]    offset;
    logic [sifhCfgPkg::NB-1:0]    binNext;
    logic                         inWin;
    logic                         updValid;
    logic [sifhCfgPkg::PIX_W-1:0] updPix;
    logic [sifhCfgPkg::NB-1:0]    updBin;

    // Window low edge of the pixel being sampled
    assign low = winLow[int'(pixIdx) * sifhCfgPkg::NP +: sifhCfgPkg::NP];

    always_comb begin
        // Distance from the low edge, no wrap since low never exceeds the top window
        offset = inData.raw - low;
        if (pass == sifhTypesPkg::COARSE) begin
            binNext = inData.split.coarse;
            inWin = 1'b1;
        end else begin
            binNext = offset[sifhCfgPkg::NB-1:0];
            // Inside when at or above low and less than one window away
            inWin = (inData.raw >= low) && (offset[sifhCfgPkg::NP-1:sifhCfgPkg::NB] == '0);
        end
    end

    // Update strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            updValid <= 1'b0;
        end else begin
            updValid <= accept && inWin;
        end
    end

    // Update payload
    always_ff @(posedge clk) begin
        updPix <= pixIdx;
        updBin <= binNext;
    end

    assign upd = '{valid: updValid, pix: updPix, bin: updBin};

endmodule

`default_nettype wire

// File: design/histogramBank.sv
//********************
// Histogram bank for all pixels
// Bin counters with written flags
// Saturating increment and peak candidate
//********************

`timescale 1ns/1ps
`default_nettype none

module histogramBank #(
    parameter int PIXELS = sifhCfgPkg::PIXELS_DEF
) (
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         clear,
    input  sifhTypesPkg::binUpd_t        upd,
    output sifhTypesPkg::peak_t          cand,
    output logic                         candValid,
    output logic [sifhCfgPkg::PIX_W-1:0] candPix
);

    localparam int DEPTH = PIXELS * sifhCfgPkg::BINS;
    localparam int ADDR_W = $clog2(DEPTH);

    // One counter per bin, pixel-major
    logic [sifhCfgPkg::CNT_W-1:0] binCnt [DEPTH];
    // Set once a bin has been written since the last clear
    logic [DEPTH-1:0]             written;

    logic [ADDR_W-1:0]            addr;
    logic [sifhCfgPkg::CNT_W-1:0] curCnt;
    logic [sifhCfgPkg::CNT_W-1:0] nextCnt;

    assign addr = ADDR_W'(int'(upd.pix) * sifhCfgPkg::BINS + int'(upd.bin));

    // Stale counters read as empty
    assign curCnt = written[addr] ? binCnt[addr] : '0;
    // Hold at full scale
    assign nextCnt = (&curCnt) ? curCnt : curCnt + 1'b1;

    //********************
    // Lazy clear

    // Whole bank emptied in one cycle by dropping the flags
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            written <= '0;
        end else if (clear) begin
            written <= '0;
        end else if (upd.valid) begin
            written[addr] <= 1'b1;
        end
    end

    //********************
    // Read-modify-write

    always_ff @(posedge clk) begin
        if (upd.valid) begin
            binCnt[addr] <= nextCnt;
        end
    end

    // Candidate strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            candValid <= 1'b0;
        end else begin
            candValid <= upd.valid && !clear;
        end
    end

    // New count of the bin just hit
    always_ff @(posedge clk) begin
        cand.bin <= upd.bin;
        cand.count <= nextCnt;
        candPix <= upd.pix;
    end

endmodule

`default_nettype wire

// File: design/peakTracker.sv
//********************
// Peak tracker
// Running maximum count and bin per pixel
//********************

`timescale 1ns/1ps
`default_nettype none

module peakTracker #(
    parameter int PIXELS = sifhCfgPkg::PIXELS_DEF
) (
    input  logic                                clk,
    input  logic                                combin_res,
    input  logic                                clear,
    input  sifhTypesPkg::peak_t                 cand,
    input  logic                                candValid,
    input  logic [sifhCfgPkg::PIX_W-1:0]        candPix,
    output sifhTypesPkg::peak_t [PIXELS-1:0]    peaks
);

    logic better;

    // Strictly greater only
    // An equal count never moves the peak, so the earliest bin wins a tie
    assign better = candValid && (cand.count > peaks[candPix].count);

    //********************
    // Peak table

    // Empty entry means bin 0 with count 0
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peaks <= '0;
        end else if (clear) begin
            peaks <= '0;
        end else if (better) begin
            peaks[candPix] <= cand;
        end
    end

endmodule

`default_nettype wire

// File: design/windowCalc.sv
//********************
// Fine window placement
// Clamped low edge per pixel from the coarse peak
// Final peak codes for the result port
//********************

`timescale 1ns/1ps
`default_nettype none

module windowCalc #(
    parameter int PIXELS = sifhCfgPkg::PIXELS_DEF
) (
    input  logic                                clk,
    input  logic                                combin_res,
    input  logic                                latchWin,
    input  sifhTypesPkg::peak_t [PIXELS-1:0]    peaks,
    output logic [PIXELS*sifhCfgPkg::NP-1:0]    winLow,
    output logic [PIXELS*sifhCfgPkg::NP-1:0]    outPeaks
);

    // Half a coarse bin below the coarse peak start
    localparam int HALF = 2 ** (sifhCfgPkg::NB - 1);
    // Highest low edge that keeps the whole window in range
    localparam int MAX_LOW = 2 ** sifhCfgPkg::NP - 2 ** sifhCfgPkg::NB;

    logic [PIXELS*sifhCfgPkg::NP-1:0] lowNext;

    //********************
    // Low edge

    always_comb begin
        int startCode;
        int edgeLow;
        lowNext = '0;
        for (int p = 0; p < PIXELS; p++) begin
            // Start code of the coarse peak bin
            startCode = int'(peaks[p].bin) << (sifhCfgPkg::NP - sifhCfgPkg::NB);
            edgeLow = startCode - HALF;
            // Clamp to the code range
            if (edgeLow < 0) begin
                edgeLow = 0;
            end else if (edgeLow > MAX_LOW) begin
                edgeLow = MAX_LOW;
            end
            lowNext[p*sifhCfgPkg::NP +: sifhCfgPkg::NP] = sifhCfgPkg::NP'(edgeLow);
        end
    end

    // Held for the whole fine pass
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            winLow <= '0;
        end else if (latchWin) begin
            winLow <= lowNext;
        end
    end

    //********************
    // Result codes

    // Low edge plus fine peak bin, one cycle behind the peak table
    always_ff @(posedge clk) begin
        for (int p = 0; p < PIXELS; p++) begin
            outPeaks[p*sifhCfgPkg::NP +: sifhCfgPkg::NP] <=
                winLow[p*sifhCfgPkg::NP +: sifhCfgPkg::NP] + sifhCfgPkg::NP'(peaks[p].bin);
        end
    end

endmodule

`default_nettype wire

// File: design/sifhTop.sv
//********************
// Two-pass histogram peak finder
// Sequencer plus filter, bank, tracker and window stages
//********************

`timescale 1ns/1ps
`default_nettype none

module sifhTop #(
    parameter int PIXELS  = sifhCfgPkg::PIXELS_DEF,
    parameter int SAMPLES = sifhCfgPkg::SAMPLES_DEF,
    parameter int ACQS    = sifhCfgPkg::ACQS_DEF
) (
    input  logic                              clk,
    input  logic                              combin_res,
    input  logic                              inValid,
    output logic                              inReady,
    input  sifhTypesPkg::sampleWord_u         inData,
    output logic                              outValid,
    input  logic                              outReady,
    output logic [PIXELS*sifhCfgPkg::NP-1:0]  outPeaks
);

    // Sequencer controls
    logic                             accept;
    sifhTypesPkg::pass_e              pass;
    logic [sifhCfgPkg::PIX_W-1:0]     pixIdx;
    logic                             latchWin;
    logic                             clear;

    // Datapath between stages
    logic [PIXELS*sifhCfgPkg::NP-1:0] winLow;
    sifhTypesPkg::binUpd_t            upd;
    sifhTypesPkg::peak_t              cand;
    logic                             candValid;
    logic [sifhCfgPkg::PIX_W-1:0]     candPix;
    sifhTypesPkg::peak_t [PIXELS-1:0] peaks;

    //********************
    // Sequencer

    sifhControl #(
        .PIXELS  (PIXELS),
        .SAMPLES (SAMPLES),
        .ACQS    (ACQS)
    ) i_sifhControl (
        .clk        (clk),
        .combin_res (combin_res),
        .inValid    (inValid),
        .inReady    (inReady),
        .outReady   (outReady),
        .outValid   (outValid),
        .accept     (accept),
        .pass       (pass),
        .pixIdx     (pixIdx),
        .latchWin   (latchWin),
        .clear      (clear)
    );

    //********************
    // Datapath

    // Sample to bin update
    sampleFilter #(
        .PIXELS (PIXELS)
    ) i_sampleFilter (
        .clk        (clk),
        .combin_res (combin_res),
        .accept     (accept),
        .pass       (pass),
        .pixIdx     (pixIdx),
        .inData     (inData),
        .winLow     (winLow),
        .upd        (upd)
    );

    // Bin counting
    histogramBank #(
        .PIXELS (PIXELS)
    ) i_histogramBank (
        .clk        (clk),
        .combin_res (combin_res),
        .clear      (clear),
        .upd        (upd),
        .cand       (cand),
        .candValid  (candValid),
        .candPix    (candPix)
    );

    // Per-pixel maximum
    peakTracker #(
        .PIXELS (PIXELS)
    ) i_peakTracker (
        .clk        (clk),
        .combin_res (combin_res),
        .clear      (clear),
        .cand       (cand),
        .candValid  (candValid),
        .candPix    (candPix),
        .peaks      (peaks)
    );

    // Window edge and final codes
    windowCalc #(
        .PIXELS (PIXELS)
    ) i_windowCalc (
        .clk        (clk),
        .combin_res (combin_res),
        .latchWin   (latchWin),
        .peaks      (peaks),
        .winLow     (winLow),
        .outPeaks   (outPeaks)
    );

endmodule

`default_nettype wire

// File: tb/sifhHandshake_chk.sv
//********************
// Handshake checker for the peak finder top level
// Result hold, input stall and reset state assertions
// Bind into sifhTop
//********************

`timescale 1ns/1ps
`default_nettype none

module sifhHandshakeChk #(
    parameter int PIXELS = sifhCfgPkg::PIXELS_DEF
) (
    input logic                              clk,
    input logic                              combin_res,
    input logic                              inReady,
    input logic                              outValid,
    input logic                              outReady,
    input logic [PIXELS*sifhCfgPkg::NP-1:0]  outPeaks
);

    // Number of assertion failures so far
    int failCount = 0;

    //********************
    // Result port

    // Result held and unchanged until taken
    holdResult: assert property (@(posedge clk) disable iff (!combin_res)
        outValid && !outReady |=> outValid && $stable(outPeaks))
        else begin
            $error("result dropped or changed before outReady");
            failCount++;
        end

    // Result gone the cycle after the handshake
    dropResult: assert property (@(posedge clk) disable iff (!combin_res)
        outValid && outReady |=> !outValid)
        else begin
            $error("outValid still high after handshake");
            failCount++;
        end

    //********************
    // Input port

    // No sample taken while a result waits
    stallInput: assert property (@(posedge clk) disable iff (!combin_res)
        outValid |-> !inReady)
        else begin
            $error("inReady high while result pending");
            failCount++;
        end

    // Ready for samples and no result right out of reset
    resetState: assert property (@(posedge clk)
        $rose(combin_res) |-> inReady && !outValid)
        else begin
            $error("wrong handshake state after reset");
            failCount++;
        end

endmodule

bind sifhTop sifhHandshakeChk #(
    .PIXELS (PIXELS)
) i_sifhHandshakeChk (
    .clk        (clk),
    .combin_res (combin_res),
    .inReady    (inReady),
    .outValid   (outValid),
    .outReady   (outReady),
    .outPeaks   (outPeaks)
);

`default_nettype wire

// File: tb/sifhTb.sv
//********************
// Testbench for the two-pass peak finder
// Frame table, sample generation, reference model
// Result checks, stall checks and timeout
//********************

`timescale 1ns/1ps
`default_nettype none

module sifhTb;

    localparam int PIXELS = sifhCfgPkg::PIXELS_DEF;
    localparam int SAMPLES = sifhCfgPkg::SAMPLES_DEF;
    localparam int ACQS = sifhCfgPkg::ACQS_DEF;
    localparam int NP = sifhCfgPkg::NP;
    localparam int NB = sifhCfgPkg::NB;
    localparam int PER_PIX = SAMPLES * ACQS;
    localparam int FRAME = PIXELS * PER_PIX;
    localparam int ROWS = 5;
    localparam int RESET_CYC = 10;
    // Drain, wrap, output and clear cycles of one frame
    localparam int FRAME_OVH = 16;

    // One frame with per pixel target, noise count and tie pattern plus outReady stall
    typedef struct packed {
        logic [PIXELS-1:0][NP-1:0] target;
        logic [PIXELS-1:0][3:0]    noise;
        logic [PIXELS-1:0]         tie;
        logic [7:0]                stall;
    } frameRow_t;

    logic                      clk = 1'b0;
    logic                      combin_res;
    logic                      inValid;
    logic                      inReady;
    sifhTypesPkg::sampleWord_u inData;
    logic                      outValid;
    logic                      outReady;
    logic [PIXELS*NP-1:0]      outPeaks;

    frameRow_t   rowTab [ROWS];
    logic [NP-1:0] stream [FRAME];
    logic [NP-1:0] expPeak [PIXELS];
    int          errors = 0;
    int          checks = 0;
    int          cycleCnt = 0;
    int          cycleLimit = 0;

    always #20 clk = ~clk;

    sifhTop #(
        .PIXELS  (PIXELS),
        .SAMPLES (SAMPLES),
        .ACQS    (ACQS)
    ) i_sifhTop (
        .clk        (clk),
        .combin_res (combin_res),
        .inValid    (inValid),
        .inReady    (inReady),
        .inData     (inData),
        .outValid   (outValid),
        .outReady   (outReady),
        .outPeaks   (outPeaks)
    );

    //********************
    // Watchdog
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= cycleLimit) begin
            $display("timeout: no result");
            $display("TESTS FAILED");
            $finish;
        end
    end

    //********************
    // Frame table and stimulus

    // Mid-range, near zero, near top, far noise with a tie, long stall
    task automatic loadTable();
        rowTab[0] = '{target: {8'hC5, 8'h4A, 8'h93, 8'h6B}, noise: {4'd1, 4'd0, 4'd1, 4'd0},
                      tie: 4'b0000, stall: 8'd0};
        rowTab[1] = '{target: {8'h5C, 8'h07, 8'h00, 8'h02}, noise: {4'd0, 4'd2, 4'd0, 4'd1},
                      tie: 4'b0000, stall: 8'd3};
        rowTab[2] = '{target: {8'h21, 8'hF6, 8'hFF, 8'hFD}, noise: {4'd1, 4'd1, 4'd2, 4'd0},
                      tie: 4'b0000, stall: 8'd0};
        rowTab[3] = '{target: {8'h64, 8'hB2, 8'h37, 8'h80}, noise: {4'd0, 4'd2, 4'd3, 4'd3},
                      tie: 4'b1000, stall: 8'd7};
        rowTab[4] = '{target: {8'h44, 8'h7A, 8'hEE, 8'h11}, noise: {4'd3, 4'd1, 4'd0, 4'd2},
                      tie: 4'b0001, stall: 8'd12};
    endtask

    // Position of a pixel's j-th sample in the input stream
    function automatic int streamIndex(input int p, input int j);
        return (j / SAMPLES) * PIXELS * SAMPLES + p * SAMPLES + (j % SAMPLES);
    endfunction

    task automatic genFrame(input frameRow_t row);
        int          val;
        int unsigned pick;
        for (int p = 0; p < PIXELS; p++) begin
            for (int j = 0; j < PER_PIX; j++) begin
                pick = $urandom % 8;
                if (row.tie[p]) begin
                    // Alternating pair with equal final counts
                    val = int'(row.target[p]) + (j % 2);
                end else if (j >= PER_PIX - int'(row.noise[p])) begin
                    // Half the code range away from the target
                    val = int'(row.target[p]) + 2 ** (NP - 1) + int'($urandom % 64) - 32;
                    val = val % (2 ** NP);
                end else if (pick == 6) begin
                    val = int'(row.target[p]) + 1;
                end else if (pick == 7) begin
                    val = int'(row.target[p]) - 1;
                end else begin
                    val = int'(row.target[p]);
                end
                if (val < 0) begin
                    val = 0;
                end else if (val > 2 ** NP - 1) begin
                    val = 2 ** NP - 1;
                end
                stream[streamIndex(p, j)] = NP'(val);
            end
        end
    endtask

    //********************
    // Reference model

    // One pixel histogram over the top bits or inside [low, low + BINS)
    task automatic histPeak(input int p, input bit fine, input int low, output int pkBin);
        int cnt [sifhCfgPkg::BINS];
        int pkCnt;
        int v;
        int b;
        pkBin = 0;
        pkCnt = 0;
        for (int i = 0; i < sifhCfgPkg::BINS; i++) begin
            cnt[i] = 0;
        end
        for (int j = 0; j < PER_PIX; j++) begin
            v = int'(stream[streamIndex(p, j)]);
            if (!fine || (v >= low && v < low + sifhCfgPkg::BINS)) begin
                b = fine ? v - low : v >> (NP - NB);
                if (cnt[b] < 2 ** sifhCfgPkg::CNT_W - 1) begin
                    cnt[b]++;
                end
                // First bin to reach the top count keeps it
                if (cnt[b] > pkCnt) begin
                    pkCnt = cnt[b];
                    pkBin = b;
                end
            end
        end
    endtask

    task automatic computeExpected();
        int coarseBin;
        int fineBin;
        int low;
        for (int p = 0; p < PIXELS; p++) begin
            histPeak(p, 1'b0, 0, coarseBin);
            low = (coarseBin << (NP - NB)) - 2 ** (NB - 1);
            if (low < 0) begin
                low = 0;
            end else if (low > 2 ** NP - sifhCfgPkg::BINS) begin
                low = 2 ** NP - sifhCfgPkg::BINS;
            end
            histPeak(p, 1'b1, low, fineBin);
            expPeak[p] = NP'(low + fineBin);
        end
    endtask

    //********************
    // Driving and checking

    // Both passes replay the same stream
    // Ready sampled at the falling edge
    task automatic sendFrame();
        int   k;
        logic ready;
        k = 0;
        inValid <= 1'b1;
        inData.raw <= stream[0];
        while (k < 2 * FRAME) begin
            @(negedge clk);
            ready = inReady;
            @(posedge clk);
            if (ready) begin
                k++;
                if (k < 2 * FRAME) begin
                    inData.raw <= stream[k % FRAME];
                end else begin
                    inValid <= 1'b0;
                end
            end
        end
    endtask

    task automatic collectResult(input frameRow_t row);
        logic [PIXELS*NP-1:0] expVec;
        for (int p = 0; p < PIXELS; p++) begin
            expVec[p*NP +: NP] = expPeak[p];
        end
        @(negedge clk);
        while (!outValid) begin
            @(negedge clk);
        end
        for (int p = 0; p < PIXELS; p++) begin
            checks++;
            if (outPeaks[p*NP +: NP] !== expPeak[p]) begin
                errors++;
                $display("mismatch outPeaks pixel %0d: got %h expected %h",
                         p, outPeaks[p*NP +: NP], expPeak[p]);
            end
        end
        // Result must sit still while outReady is low
        for (int i = 0; i < int'(row.stall); i++) begin
            @(negedge clk);
            checks++;
            if (outPeaks !== expVec) begin
                errors++;
                $display("mismatch outPeaks in stall: got %h expected %h", outPeaks, expVec);
            end
            if (inReady !== 1'b0 || outValid !== 1'b1) begin
                errors++;
                $display("mismatch inReady/outValid in stall: got %h/%h expected 0/1",
                         inReady, outValid);
            end
        end
        @(posedge clk);
        outReady <= 1'b1;
        @(posedge clk);
        outReady <= 1'b0;
    endtask

    //********************
    // Main sequence
    initial begin
        int stallSum;
        combin_res = 1'b0;
        inValid = 1'b0;
        inData = '0;
        outReady = 1'b0;
        void'($urandom(32'hbf4e8c1e));
        loadTable();
        stallSum = 0;
        for (int r = 0; r < ROWS; r++) begin
            stallSum += int'(rowTab[r].stall);
        end
        cycleLimit = ROWS * (2 * FRAME + FRAME_OVH) + stallSum + RESET_CYC + 50;

        repeat (RESET_CYC) @(posedge clk);
        combin_res <= 1'b1;
        @(negedge clk);
        checks++;
        if (inReady !== 1'b1 || outValid !== 1'b0) begin
            errors++;
            $display("mismatch inReady/outValid after reset: got %h/%h expected 1/0",
                     inReady, outValid);
        end
        @(posedge clk);

        // Back to back frames with a fresh model result each
        for (int r = 0; r < ROWS; r++) begin
            genFrame(rowTab[r]);
            computeExpected();
            sendFrame();
            collectResult(rowTab[r]);
        end

        errors += i_sifhTop.i_sifhHandshakeChk.failCount;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
design/sifhCfgPkg.sv
design/sifhTypesPkg.sv
design/sifhControl.sv
design/sampleFilter.sv
design/histogramBank.sv
design/peakTracker.sv
design/windowCalc.sv
design/sifhTop.sv
tb/sifhHandshake_chk.sv
tb/sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  # Packages first, the RTL depends on them
  - design/sifhCfgPkg.sv
  - design/sifhTypesPkg.sv
  - design/sifhControl.sv
  - design/sampleFilter.sv
  - design/histogramBank.sv
  - design/peakTracker.sv
  - design/windowCalc.sv
  - design/sifhTop.sv
  - target: test
    files:
      - tb/sifhHandshake_chk.sv
      - tb/sifhTb.sv
